// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --timescale 1ns/1ps -j 0
TOP       := tb_mem_channel
FILELIST  := mem_channel_top.f
BUILD_DIR := obj_dir
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== hw/credit_fifo.sv ====
`timescale 1ns/1ps

module credit_fifo #(
    parameter type payload_t    = logic,
    parameter int  DEPTH        = 4,
    parameter int  INIT_CREDITS = 0
) (
    input  logic     clock_i,
    input  logic     reset_ni,
    input  logic     push_valid,
    input  payload_t push_data,
    input  logic     credit_in,
    output logic     credit_out,
    output logic     pop_valid,
    output payload_t pop_data
);

    localparam int PTR_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W    = $clog2(DEPTH + 1);
    localparam int CREDIT_W = 16;

    payload_t            buffer [DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic [CREDIT_W-1:0] credits;
    logic                pop;
    logic                credit_take;

    // Pop needs an entry and a downstream credit
    assign pop         = (count != '0) && (credits != '0);
    assign pop_valid   = pop;
    assign pop_data    = buffer[rd_ptr];
    // Every pop frees one slot, which goes back upstream as a credit
    assign credit_out  = pop;

    // Saturate rather than wrap the credit count
    assign credit_take = credit_in && (credits != '1);

    always_ff @(posedge clock_i) begin
        if (push_valid) begin
            buffer[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clock_i or negedge reset_ni) begin
        if (!reset_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push_valid) - CNT_W'(pop);
        end
    end

    // Downstream credits, spent one per pop
    always_ff @(posedge clock_i or negedge reset_ni) begin
        if (!reset_ni) begin
            credits <= CREDIT_W'(INIT_CREDITS);
        end else begin
            credits <= credits + CREDIT_W'(credit_take) - CREDIT_W'(pop);
        end
    end

endmodule

// ==== hw/line_lane_adapter.sv ====
`timescale 1ns/1ps
`include "mem_channel_defines.svh"

module line_lane_adapter
    import mem_channel_pkg::*;
(
    input  host_req_t word_req,
    input  logic      word_req_valid,
    input  line_rsp_t line_rsp,
    input  logic      line_rsp_valid,
    output line_req_t line_req,
    output logic      line_req_valid,
    output host_rsp_t word_rsp,
    output logic      word_rsp_valid
);

    localparam int HOST_W      = `MEM_HOST_DATA_W;
    localparam int HOST_STRB_W = `MEM_HOST_STRB_W;
    localparam int LINE_STRB_W = `MEM_LINE_STRB_W;
    localparam int LANE_LSB    = `MEM_BYTE_OFF_W;
    localparam int LINE_LSB    = LANE_LSB + `MEM_LANE_IDX_W;

    logic [`MEM_LANE_IDX_W-1:0] req_lane;

    // Byte address is split as line | lane | byte, upper bits fall away
    assign req_lane = word_req.addr[LANE_LSB +: `MEM_LANE_IDX_W];

    always_comb begin
        line_req.write    = word_req.write;
        line_req.line_idx = word_req.addr[LINE_LSB +: `MEM_LINE_IDX_W];
        line_req.lane     = req_lane;
        // Same word on every lane, the strobe decides which one lands
        line_req.data     = {`MEM_LANES{word_req.wdata}};
        line_req.strb     = LINE_STRB_W'(word_req.strb) << (req_lane * HOST_STRB_W);
    end

    assign line_req_valid = word_req_valid;

    // Narrow the returned line back to the addressed word
    always_comb begin
        word_rsp.write = line_rsp.write;
        if (line_rsp.write) begin
            word_rsp.rdata = '0;
        end else begin
            word_rsp.rdata = line_rsp.data[line_rsp.lane * HOST_W +: HOST_W];
        end
    end

    assign word_rsp_valid = line_rsp_valid;

endmodule

// ==== hw/line_memory.sv ====
`timescale 1ns/1ps
`include "mem_channel_defines.svh"

module line_memory
    import mem_channel_pkg::*;
(
    input  logic      clock_i,
    input  logic      reset_ni,
    input  logic      req_valid,
    input  line_req_t req,
    output logic      rsp_valid,
    output line_rsp_t rsp
);

    localparam int LINE_BYTES = `MEM_LINE_W / 8;

    logic [`MEM_LINE_W-1:0]   mem [`MEM_LINES];
    logic [`MEM_LATENCY-1:0]  valid_q;
    line_rsp_t                stage_q [`MEM_LATENCY];

    // Only strobed bytes of the line are updated
    always_ff @(posedge clock_i) begin
        if (req_valid && req.write) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (req.strb[b]) begin
                    mem[req.line_idx][b*8 +: 8] <= req.data[b*8 +: 8];
                end
            end
        end
    end

    // Valid shift register, one slot per cycle of latency
    always_ff @(posedge clock_i or negedge reset_ni) begin
        if (!reset_ni) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= req_valid;
            for (int s = 1; s < `MEM_LATENCY; s++) begin
                valid_q[s] <= valid_q[s-1];
            end
        end
    end

    // Read happens in the first stage
    // a write one cycle earlier is already in the array by then
    always_ff @(posedge clock_i) begin
        if (req_valid) begin
            stage_q[0].write <= req.write;
            stage_q[0].lane  <= req.lane;
            stage_q[0].data  <= mem[req.line_idx];
        end
        for (int s = 1; s < `MEM_LATENCY; s++) begin
            stage_q[s] <= stage_q[s-1];
        end
    end

    assign rsp_valid = valid_q[`MEM_LATENCY-1];
    assign rsp       = stage_q[`MEM_LATENCY-1];

endmodule

// ==== hw/mem_channel_pkg.sv ====
`include "mem_channel_defines.svh"

package mem_channel_pkg;

    // Word request from the host
    typedef struct packed {
        logic                           write;
        logic [`MEM_ADDR_W-1:0]         addr;
        logic [`MEM_HOST_DATA_W-1:0]    wdata;
        logic [`MEM_HOST_STRB_W-1:0]    strb;
    } host_req_t;

    // Word response, rdata is zero for writes
    typedef struct packed {
        logic                           write;
        logic [`MEM_HOST_DATA_W-1:0]    rdata;
    } host_rsp_t;

    // Line request toward the memory
    typedef struct packed {
        logic                           write;
        logic [`MEM_LINE_IDX_W-1:0]     line_idx;
        logic [`MEM_LANE_IDX_W-1:0]     lane;
        logic [`MEM_LINE_W-1:0]         data;
        logic [`MEM_LINE_STRB_W-1:0]    strb;
    } line_req_t;

    // Line response, lane travels along so the word can be picked out
    typedef struct packed {
        logic                           write;
        logic [`MEM_LANE_IDX_W-1:0]     lane;
        logic [`MEM_LINE_W-1:0]         data;
    } line_rsp_t;

endpackage

// ==== hw/mem_channel_top.sv ====
`timescale 1ns/1ps
`include "mem_channel_defines.svh"

module mem_channel_top
    import mem_channel_pkg::*;
(
    input  logic      clock_i,
    input  logic      reset_ni,
    input  logic      req_valid,
    input  host_req_t req,
    output logic      req_credit,
    input  logic      rsp_credit,
    output logic      rsp_valid,
    output host_rsp_t rsp,
    output logic      calib_done
);

    logic      core_reset_n;
    logic      word_req_valid;
    host_req_t word_req;
    logic      line_req_valid;
    line_req_t line_req;
    logic      line_rsp_valid;
    line_rsp_t line_rsp;
    logic      word_rsp_valid;
    host_rsp_t word_rsp;
    // Freed response slots, handed back to the request queue
    logic      rsp_slot_credit;

    mem_init_ctrl u_init (
        .clock_i      ( clock_i      ),
        .reset_ni     ( reset_ni     ),
        .core_reset_n ( core_reset_n ),
        .calib_done   ( calib_done   )
    );

    // Starts with one credit per response queue slot
    credit_fifo #(
        .payload_t    ( host_req_t     ),
        .DEPTH        ( `MEM_REQ_DEPTH ),
        .INIT_CREDITS ( `MEM_RSP_DEPTH )
    ) u_req_queue (
        .clock_i    ( clock_i         ),
        .reset_ni   ( core_reset_n    ),
        .push_valid ( req_valid       ),
        .push_data  ( req             ),
        .credit_in  ( rsp_slot_credit ),
        .credit_out ( req_credit      ),
        .pop_valid  ( word_req_valid  ),
        .pop_data   ( word_req        )
    );

    line_lane_adapter u_adapter (
        .word_req       ( word_req       ),
        .word_req_valid ( word_req_valid ),
        .line_rsp       ( line_rsp       ),
        .line_rsp_valid ( line_rsp_valid ),
        .line_req       ( line_req       ),
        .line_req_valid ( line_req_valid ),
        .word_rsp       ( word_rsp       ),
        .word_rsp_valid ( word_rsp_valid )
    );

    line_memory u_memory (
        .clock_i   ( clock_i        ),
        .reset_ni  ( core_reset_n   ),
        .req_valid ( line_req_valid ),
        .req       ( line_req       ),
        .rsp_valid ( line_rsp_valid ),
        .rsp       ( line_rsp       )
    );

    // Host grants the credits on this side
    credit_fifo #(
        .payload_t    ( host_rsp_t     ),
        .DEPTH        ( `MEM_RSP_DEPTH ),
        .INIT_CREDITS ( 0              )
    ) u_rsp_queue (
        .clock_i    ( clock_i         ),
        .reset_ni   ( core_reset_n    ),
        .push_valid ( word_rsp_valid  ),
        .push_data  ( word_rsp        ),
        .credit_in  ( rsp_credit      ),
        .credit_out ( rsp_slot_credit ),
        .pop_valid  ( rsp_valid       ),
        .pop_data   ( rsp             )
    );

endmodule

// ==== hw/mem_init_ctrl.sv ====
`timescale 1ns/1ps
`include "mem_channel_defines.svh"

module mem_init_ctrl (
    input  logic clock_i,
    input  logic reset_ni,
    output logic core_reset_n,
    output logic calib_done
);

    localparam int CNT_W = $clog2(`MEM_CALIB_CYCLES + 1);

    logic [CNT_W-1:0] calib_cnt;

    // Free-running until the calibration length is reached, then holds
    always_ff @(posedge clock_i or negedge reset_ni) begin
        if (!reset_ni) begin
            calib_cnt <= '0;
        end else if (calib_cnt != CNT_W'(`MEM_CALIB_CYCLES)) begin
            calib_cnt <= calib_cnt + 1'b1;
        end
    end

    // Datapath leaves reset on the same edge that calib_done rises
    always_ff @(posedge clock_i or negedge reset_ni) begin
        if (!reset_ni) begin
            core_reset_n <= 1'b0;
            calib_done   <= 1'b0;
        end else if (calib_cnt == CNT_W'(`MEM_CALIB_CYCLES - 1)) begin
            core_reset_n <= 1'b1;
            calib_done   <= 1'b1;
        end
    end

endmodule

// ==== include/mem_channel_defines.svh ====
`ifndef MEM_CHANNEL_DEFINES_SVH
`define MEM_CHANNEL_DEFINES_SVH

// Host word port
`define MEM_ADDR_W         32
`define MEM_HOST_DATA_W    32
`define MEM_HOST_STRB_W    (`MEM_HOST_DATA_W / 8)

// Line geometry, 256 lines of 64 bytes
`define MEM_LINE_W         512
`define MEM_LINE_STRB_W    (`MEM_LINE_W / 8)
`define MEM_LANES          16
`define MEM_LINES          256
`define MEM_BYTE_OFF_W     ($clog2(`MEM_HOST_STRB_W))
`define MEM_LANE_IDX_W     ($clog2(`MEM_LANES))
`define MEM_LINE_IDX_W     ($clog2(`MEM_LINES))

// Pipeline and queue sizing
`define MEM_LATENCY        3
`define MEM_REQ_DEPTH      4
`define MEM_RSP_DEPTH      4

// Cycles from reset release to calib_done
`define MEM_CALIB_CYCLES   16

`endif

// ==== mem_channel_top.f ====
+incdir+include
hw/mem_channel_pkg.sv
hw/mem_init_ctrl.sv
hw/credit_fifo.sv
hw/line_lane_adapter.sv
hw/line_memory.sv
hw/mem_channel_top.sv
tb/mem_channel_checker.sv
tb/tb_mem_channel.sv

// ==== tb/mem_channel_checker.sv ====
`timescale 1ns/1ps
`include "mem_channel_defines.svh"

module mem_channel_checker
    import mem_channel_pkg::*;
(
    input  logic            clock_i,
    input  logic            reset_ni,
    input  logic            calib_done,
    input  logic            req_valid,
    input  logic            req_credit,
    input  logic            rsp_credit,
    input  logic            rsp_valid,
    input  host_rsp_t       rsp,
    input  logic            exp_valid,
    input  host_rsp_t       exp_rsp,
    input  logic [8*16-1:0] exp_name,
    input  logic            end_check,
    output int              error_count,
    output int              pending
);

    host_rsp_t       exp_q [$];
    logic [8*16-1:0] name_q [$];
    int              errors;
    int              cycle_cnt;
    int              req_cnt;
    int              req_credit_cnt;
    int              grant_cnt;
    int              rsp_cnt;

    // All values are sampled at the rising edge, before the DUT updates
    always @(posedge clock_i) begin
        host_rsp_t       expected;
        logic [8*16-1:0] name;
        if (!reset_ni) begin
            cycle_cnt      = 0;
            req_cnt        = 0;
            req_credit_cnt = 0;
            grant_cnt      = 0;
            rsp_cnt        = 0;
        end else begin
            cycle_cnt++;
            // calib_done must rise exactly MEM_CALIB_CYCLES cycles after release
            if (cycle_cnt <= `MEM_CALIB_CYCLES + 1 &&
                calib_done !== (cycle_cnt > `MEM_CALIB_CYCLES)) begin
                $display("calib_done is %b in cycle %0d after reset release", calib_done,
                         cycle_cnt);
                errors++;
            end
            if (!calib_done && (rsp_valid || req_credit || req_valid)) begin
                $display("Port activity seen before calib_done in cycle %0d", cycle_cnt);
                errors++;
            end
            if (req_credit && req_credit_cnt >= req_cnt) begin
                $display("Request credit returned with no request left to match");
                errors++;
            end
            if (rsp_valid && rsp_cnt >= grant_cnt) begin
                $display("Response sent without an unspent host credit");
                errors++;
            end
            if (req_credit) req_credit_cnt++;
            if (req_valid) req_cnt++;
            if (rsp_credit && calib_done) grant_cnt++;
            if (exp_valid) begin
                exp_q.push_back(exp_rsp);
                name_q.push_back(exp_name);
            end
            if (rsp_valid) begin
                rsp_cnt++;
                if (exp_q.size() == 0) begin
                    $display("Response arrived with no request outstanding");
                    errors++;
                end else begin
                    expected = exp_q.pop_front();
                    name     = name_q.pop_front();
                    if (rsp !== expected) begin
                        $display("Fail %s: expected write=%b rdata=%h, actual write=%b rdata=%h",
                                 name, expected.write, expected.rdata, rsp.write, rsp.rdata);
                        errors++;
                    end
                end
            end
            if (end_check && exp_q.size() != 0) begin
                $display("%0d responses still missing at the end of the run", exp_q.size());
                errors++;
            end
        end
        error_count <= errors;
        pending     <= exp_q.size();
    end

endmodule

// ==== tb/tb_mem_channel.sv ====
`timescale 1ns/1ps
`include "mem_channel_defines.svh"

module tb_mem_channel
    import mem_channel_pkg::*;
();

    localparam int RESET_CYCLES = 5;
    // Response credits held back this long after calib_done so both queues fill
    localparam int HOLD_CYCLES  = 24;
    localparam int DRAIN_LIMIT  = 200;

    typedef struct packed {
        logic [8*16-1:0]             name;
        host_req_t                   req;
        logic [`MEM_HOST_DATA_W-1:0] exp_word;
    } stim_t;

    logic            clock_i    = 1'b0;
    logic            reset_ni;
    logic            req_valid;
    host_req_t       req;
    logic            req_credit;
    logic            rsp_credit = 1'b0;
    logic            rsp_valid;
    host_rsp_t       rsp;
    logic            calib_done;
    logic            exp_valid;
    host_rsp_t       exp_rsp;
    logic [8*16-1:0] exp_name;
    logic            end_check;
    int              error_count;
    int              pending;
    int              watchdog_cycles = 0;
    int              hold_cnt;
    logic [31:0]     lcg_state;
    stim_t           stim_table [$];

    always #10 clock_i = ~clock_i;

    mem_channel_top u_mem_channel_top (
        .clock_i    ( clock_i    ),
        .reset_ni   ( reset_ni   ),
        .req_valid  ( req_valid  ),
        .req        ( req        ),
        .req_credit ( req_credit ),
        .rsp_credit ( rsp_credit ),
        .rsp_valid  ( rsp_valid  ),
        .rsp        ( rsp        ),
        .calib_done ( calib_done )
    );

    mem_channel_checker u_checker (
        .clock_i     ( clock_i     ),
        .reset_ni    ( reset_ni    ),
        .calib_done  ( calib_done  ),
        .req_valid   ( req_valid   ),
        .req_credit  ( req_credit  ),
        .rsp_credit  ( rsp_credit  ),
        .rsp_valid   ( rsp_valid   ),
        .rsp         ( rsp         ),
        .exp_valid   ( exp_valid   ),
        .exp_rsp     ( exp_rsp     ),
        .exp_name    ( exp_name    ),
        .end_check   ( end_check   ),
        .error_count ( error_count ),
        .pending     ( pending     )
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Distinct word per lane of the sweep line
    function automatic logic [31:0] lane_word(input int lane);
        return 32'h9100_0000 + 32'(lane) * 32'h0001_0203;
    endfunction

    task automatic add_entry(input logic [8*16-1:0] name, input logic write,
                             input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] strb, input logic [31:0] exp_word);
        stim_t entry;
        entry.name     = name;
        entry.req      = '{write: write, addr: addr, wdata: wdata, strb: strb};
        entry.exp_word = exp_word;
        stim_table.push_back(entry);
    endtask

    task automatic build_table();
        logic [8*16-1:0] name;
        // Line 5 lane 0, full word then two partial merges
        add_entry("full_wr", 1'b1, 32'h0000_0140, 32'hDEAD_BEEF, 4'hF, '0);
        add_entry("full_rd", 1'b0, 32'h0000_0140, '0, 4'h0, 32'hDEAD_BEEF);
        add_entry("part_wr_a", 1'b1, 32'h0000_0140, 32'h1122_3344, 4'h5, '0);
        add_entry("part_rd_a", 1'b0, 32'h0000_0140, '0, 4'h0, 32'hDE22_BE44);
        add_entry("part_wr_b", 1'b1, 32'h0000_0140, 32'hAABB_CCDD, 4'hA, '0);
        add_entry("part_rd_b", 1'b0, 32'h0000_0140, '0, 4'h0, 32'hAA22_CC44);
        // Every lane of line 9
        for (int lane = 0; lane < `MEM_LANES; lane++) begin
            $sformat(name, "lane_wr_%0d", lane);
            add_entry(name, 1'b1, 32'h0000_0240 + 32'(lane * 4), lane_word(lane), 4'hF, '0);
        end
        for (int lane = 0; lane < `MEM_LANES; lane++) begin
            $sformat(name, "lane_rd_%0d", lane);
            add_entry(name, 1'b0, 32'h0000_0240 + 32'(lane * 4), '0, 4'h0, lane_word(lane));
        end
        // Address bits from 14 up fall outside the 16 KiB array
        add_entry("alias_rd", 1'b0, 32'h0001_4244, '0, 4'h0, lane_word(1));
        add_entry("alias_wr", 1'b1, 32'h8000_0248, 32'h5A5A_0F0F, 4'hF, '0);
        add_entry("alias_rd_b", 1'b0, 32'h0000_0248, '0, 4'h0, 32'h5A5A_0F0F);
        add_entry("line5_rd", 1'b0, 32'h0000_0140, '0, 4'h0, 32'hAA22_CC44);
    endtask

    task automatic send_request(input stim_t entry);
        req_valid     <= 1'b1;
        req           <= entry.req;
        exp_valid     <= 1'b1;
        exp_name      <= entry.name;
        exp_rsp.write <= entry.req.write;
        // Write acknowledge carries no data
        exp_rsp.rdata <= entry.req.write ? '0 : entry.exp_word;
    endtask

    // Random response credits once the hold period is over
    always @(posedge clock_i) begin
        if (!reset_ni) begin
            rsp_credit <= 1'b0;
            lcg_state  <= 32'd25;
            hold_cnt   <= 0;
        end else if (!calib_done || hold_cnt < HOLD_CYCLES) begin
            rsp_credit <= 1'b0;
            if (calib_done) hold_cnt <= hold_cnt + 1;
        end else begin
            lcg_state  <= lcg_next(lcg_state);
            rsp_credit <= lcg_state[31];
        end
    end

    initial begin
        int idx;
        int drain;
        int host_credits;
        reset_ni     = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        exp_valid    = 1'b0;
        exp_rsp      = '0;
        exp_name     = '0;
        end_check    = 1'b0;
        host_credits = `MEM_REQ_DEPTH;
        build_table();
        watchdog_cycles = stim_table.size() * (`MEM_LATENCY + 20) + `MEM_CALIB_CYCLES + 100;
        repeat (RESET_CYCLES) @(posedge clock_i);
        reset_ni <= 1'b1;
        while (!calib_done) @(posedge clock_i);
        idx = 0;
        while (idx < stim_table.size()) begin
            @(posedge clock_i);
            if (req_credit) host_credits++;
            if (host_credits > 0) begin
                send_request(stim_table[idx]);
                host_credits--;
                idx++;
            end else begin
                req_valid <= 1'b0;
                exp_valid <= 1'b0;
            end
        end
        @(posedge clock_i);
        req_valid <= 1'b0;
        exp_valid <= 1'b0;
        @(posedge clock_i);
        drain = 0;
        while (pending != 0 && drain < DRAIN_LIMIT) begin
            @(posedge clock_i);
            drain++;
        end
        end_check <= 1'b1;
        @(posedge clock_i);
        end_check <= 1'b0;
        repeat (2) @(posedge clock_i);
        $display("Run complete: %0d requests, %0d errors", stim_table.size(), error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clock_i);
        $display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("Test failures found");
        $finish;
    end

endmodule
